/* logic/ecc_params.svh */
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// Width of the protected data word.
`define ECC_DATA_WIDTH 96

// Seven position check bits plus one overall weight bit.
`define ECC_PARITY_WIDTH 8

// Check bits that hold the Hamming position of a data bit.
`define ECC_HAMMING_BITS 7

`endif

/* logic/ecc_pkg.sv */
`default_nettype none

package ecc_pkg;

    `include "ecc_params.svh"

    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_syndrome_t;

    // Data bit idx sits at the idx-th position from 3 up that is not a power of two.
    // The top bit makes the column weight odd.
    function automatic ecc_parity_t ecc_column(input int unsigned idx);
        int unsigned seen;
        int unsigned pos;
        logic [`ECC_HAMMING_BITS-1:0] low;
        seen = 0;
        pos  = 0;
        for (int unsigned p = 3; p < (1 << `ECC_HAMMING_BITS); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (seen == idx) begin
                    pos = p;
                end
                seen++;
            end
        end
        low = pos[`ECC_HAMMING_BITS-1:0];
        return {~^low, low};
    endfunction

endpackage

`default_nettype wire

/* logic/ecc_check_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ecc_check_if
    import ecc_pkg::*;
();

    logic      valid;
    ecc_data_t data;
    logic      bypass;
    // One-hot, or zero when no data bit is to be flipped.
    ecc_data_t mask;
    logic      sbit;
    logic      dbit;

    modport producer (output valid, data, bypass, mask, sbit, dbit);

    modport consumer (input valid, data, bypass, mask, sbit, dbit);

endinterface

`default_nettype wire

/* logic/ecc_parity_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_parity_gen
    import ecc_pkg::*;
(
    input  ecc_data_t   data,
    output ecc_parity_t parity
);

    // Set of data bits that feed check bit j.
    function automatic ecc_data_t column_select(input int unsigned j);
        ecc_data_t   sel;
        ecc_parity_t col;
        sel = '0;
        for (int unsigned k = 0; k < $bits(ecc_data_t); k++) begin
            col = ecc_column(k);
            sel[k] = col[j];
        end
        return sel;
    endfunction

    ecc_data_t terms [$bits(ecc_parity_t)];

    genvar j;
    generate
        for (j = 0; j < $bits(ecc_parity_t); j++) begin : g_check
            localparam ecc_data_t col_sel = column_select(j);

            // Keep only the data bits covered by this check bit.
            assign terms[j] = data & col_sel;

            assign parity[j] = ^terms[j];
        end
    endgenerate

endmodule

`default_nettype wire

/* logic/ecc_syndrome_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_syndrome_decode
    import ecc_pkg::*;
(
    input  logic        valid,
    input  ecc_data_t   data,
    input  logic        bypass,
    input  ecc_parity_t parity_stored,
    input  ecc_parity_t parity_calc,
    ecc_check_if.producer chk
);

    ecc_syndrome_t syndrome;
    ecc_syndrome_t syndrome_less_one;
    ecc_data_t     flip_mask;
    logic          syndrome_zero;
    logic          syndrome_one_hot;
    logic          column_hit;

    assign syndrome = parity_stored ^ parity_calc;

    // Each data bit owns exactly one syndrome value, its column.
    genvar k;
    generate
        for (k = 0; k < $bits(ecc_data_t); k++) begin : g_match
            localparam ecc_parity_t col = ecc_column(k);

            assign flip_mask[k] = (syndrome == col);
        end
    endgenerate

    assign column_hit = |flip_mask;

    assign syndrome_zero = (syndrome == '0);

    // A lone set bit points at a check bit, not at data.
    assign syndrome_less_one = syndrome - ecc_syndrome_t'(1);
    assign syndrome_one_hot  = !syndrome_zero && ((syndrome & syndrome_less_one) == '0);

    assign chk.valid  = valid;
    assign chk.data   = data;
    assign chk.bypass = bypass;
    assign chk.mask   = flip_mask;

    assign chk.sbit = column_hit || syndrome_one_hot;

    // Even-weight or unused syndromes cannot be corrected.
    assign chk.dbit = !syndrome_zero && !column_hit && !syndrome_one_hot;

endmodule

`default_nettype wire

/* logic/ecc_correct_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    ecc_check_if.consumer chk,
    output logic          out_valid,
    output ecc_data_t     data_out,
    output logic          sbit_err,
    output logic          dbit_err
);

    ecc_data_t data_next;

    // Bypass returns the word exactly as presented.
    assign data_next = chk.bypass ? chk.data : (chk.data ^ chk.mask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            data_out  <= '0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            out_valid <= chk.valid;
            sbit_err  <= chk.valid && !chk.bypass && chk.sbit;
            dbit_err  <= chk.valid && !chk.bypass && chk.dbit;
            // Holds the last accepted word between valid cycles.
            if (chk.valid) begin
                data_out <= data_next;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ecc_96_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_params.svh"

module ecc_96_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [`ECC_DATA_WIDTH-1:0]   data_in,
    input  logic [`ECC_PARITY_WIDTH-1:0] parity_in,
    input  logic                         bypass,
    output logic [`ECC_PARITY_WIDTH-1:0] parity_out,
    output logic                         out_valid,
    output logic [`ECC_DATA_WIDTH-1:0]   data_out,
    output logic                         sbit_err,
    output logic                         dbit_err
);

    ecc_check_if chk_if ();

    // Check bits for the write path, also reused for the read check.
    ecc_parity_gen u_parity_gen (
        .data   (data_in),
        .parity (parity_out)
    );

    ecc_syndrome_decode u_syndrome_decode (
        .valid         (in_valid),
        .data          (data_in),
        .bypass        (bypass),
        .parity_stored (parity_in),
        .parity_calc   (parity_out),
        .chk           (chk_if.producer)
    );

    ecc_correct_stage u_correct_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .chk       (chk_if.consumer),
        .out_valid (out_valid),
        .data_out  (data_out),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

endmodule

`default_nettype wire

/* sim/ecc_tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_tb_clock (
    output logic clk,
    output logic rst_n
);

    // 10 ns period, first rising edge at 5 ns.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset is released just after the fourth rising edge.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/ecc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_params.svh"

module ecc_checker #(
    parameter int NAME_BITS = 128
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [`ECC_PARITY_WIDTH-1:0] parity_out,
    input  logic                         out_valid,
    input  logic [`ECC_DATA_WIDTH-1:0]   data_out,
    input  logic                         sbit_err,
    input  logic                         dbit_err,
    input  logic [NAME_BITS-1:0]         exp_name,
    input  logic [`ECC_PARITY_WIDTH-1:0] exp_parity,
    input  logic [`ECC_DATA_WIDTH-1:0]   exp_data,
    input  logic                         exp_sbit,
    input  logic                         exp_dbit,
    output int                           checked,
    output int                           errors
);

    int n_checked = 0;
    int n_errors  = 0;

    // Expectation of the row driven in the previous cycle.
    logic                       held_valid = 1'b0;
    logic                       held_bad   = 1'b0;
    logic [NAME_BITS-1:0]       held_name;
    logic [`ECC_DATA_WIDTH-1:0] held_data;
    logic                       held_sbit;
    logic                       held_dbit;

    assign checked = n_checked;
    assign errors  = n_errors;

    // Sampled on the falling edge, where inputs and registered outputs are settled.
    always @(negedge clk) begin
        logic row_bad;
        if (!rst_n) begin
            held_valid = 1'b0;
            if (out_valid || sbit_err || dbit_err) begin
                $display("Outputs not low during reset: out_valid=%b sbit_err=%b dbit_err=%b",
                         out_valid, sbit_err, dbit_err);
                n_errors++;
            end
        end else begin
            if (out_valid && !held_valid) begin
                $display("out_valid is high without a word accepted the cycle before");
                n_errors++;
            end
            if (!out_valid && (sbit_err || dbit_err)) begin
                $display("Error flag high while out_valid is low");
                n_errors++;
            end
            if (held_valid && !out_valid) begin
                $display("No out_valid one cycle after %0s was accepted", held_name);
                n_errors++;
                n_checked++;
            end else if (held_valid) begin
                row_bad = held_bad;
                if (data_out !== held_data) begin
                    $display("MISMATCH %0s data_out expected %h actual %h",
                             held_name, held_data, data_out);
                    row_bad = 1'b1;
                end
                if (sbit_err !== held_sbit) begin
                    $display("MISMATCH %0s sbit_err expected %b actual %b",
                             held_name, held_sbit, sbit_err);
                    row_bad = 1'b1;
                end
                if (dbit_err !== held_dbit) begin
                    $display("MISMATCH %0s dbit_err expected %b actual %b",
                             held_name, held_dbit, dbit_err);
                    row_bad = 1'b1;
                end
                if (row_bad) begin
                    n_errors++;
                end
                $display("%s %0s", row_bad ? "FAIL" : "PASS", held_name);
                n_checked++;
            end

            held_valid = in_valid;
            if (in_valid) begin
                held_name = exp_name;
                held_data = exp_data;
                held_sbit = exp_sbit;
                held_dbit = exp_dbit;
                held_bad  = 1'b0;
                // Write-path check bits are combinational, so compare them in the drive cycle.
                if (parity_out !== exp_parity) begin
                    $display("MISMATCH %0s parity_out expected %h actual %h",
                             exp_name, exp_parity, parity_out);
                    held_bad = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/ecc_96_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ecc_params.svh"

module ecc_96_tb;

    localparam int ROWS           = 24;
    localparam int NAME_BITS      = 128;
    localparam int TIMEOUT_CYCLES = 20;

    typedef logic [`ECC_DATA_WIDTH-1:0]   word_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] check_t;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    word_t  data_in;
    check_t parity_in;
    logic   bypass;
    check_t parity_out;
    logic   out_valid;
    word_t  data_out;
    logic   sbit_err;
    logic   dbit_err;

    logic [NAME_BITS-1:0] exp_name;
    check_t               exp_parity;
    word_t                exp_data;
    logic                 exp_sbit;
    logic                 exp_dbit;
    int                   checked;
    int                   errors;

    // Stimulus table, one entry per row.
    logic [NAME_BITS-1:0] tbl_name     [ROWS];
    word_t                tbl_data     [ROWS];
    word_t                tbl_dflip    [ROWS];
    check_t               tbl_cflip    [ROWS];
    logic                 tbl_bypass   [ROWS];
    word_t                tbl_exp_data [ROWS];
    logic                 tbl_exp_sbit [ROWS];
    logic                 tbl_exp_dbit [ROWS];
    int                   n_rows = 0;

    ecc_tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ecc_96_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .parity_out (parity_out),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_checker #(
        .NAME_BITS (NAME_BITS)
    ) u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .parity_out (parity_out),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .exp_name   (exp_name),
        .exp_parity (exp_parity),
        .exp_data   (exp_data),
        .exp_sbit   (exp_sbit),
        .exp_dbit   (exp_dbit),
        .checked    (checked),
        .errors     (errors)
    );

    // Walks the Hamming positions from 3 up, skipping powers of two.
    function automatic check_t ref_encode(input word_t d);
        check_t      c;
        int unsigned pos;
        int unsigned k;
        c   = '0;
        k   = 0;
        pos = 3;
        while (k < `ECC_DATA_WIDTH) begin
            if ($countones(pos) > 1) begin
                if (d[k]) begin
                    c[6:0] ^= pos[6:0];
                    // Even-weight positions also feed the top bit.
                    if (($countones(pos) % 2) == 0) begin
                        c[7] ^= 1'b1;
                    end
                end
                k++;
            end
            pos++;
        end
        return c;
    endfunction

    function automatic word_t random_word();
        return {$urandom(), $urandom(), $urandom()};
    endfunction

    task automatic add_row(input string name, input word_t d, input word_t dflip,
                           input check_t cflip, input logic byp, input word_t exp_d,
                           input logic sbit, input logic dbit);
        logic [NAME_BITS-1:0] packed_name;
        $sformat(packed_name, "%s", name);
        tbl_name[n_rows]     = packed_name;
        tbl_data[n_rows]     = d;
        tbl_dflip[n_rows]    = dflip;
        tbl_cflip[n_rows]    = cflip;
        tbl_bypass[n_rows]   = byp;
        tbl_exp_data[n_rows] = exp_d;
        tbl_exp_sbit[n_rows] = sbit;
        tbl_exp_dbit[n_rows] = dbit;
        n_rows++;
    endtask

    task automatic fill_table();
        word_t       d;
        word_t       flip;
        int unsigned a;
        int unsigned b;
        int unsigned c;
        for (int i = 0; i < 3; i++) begin
            d = random_word();
            add_row($sformatf("clean_%0d", i), d, '0, '0, 1'b0, d, 1'b0, 1'b0);
        end
        d = random_word();
        add_row("data_bit0", d, word_t'(1), '0, 1'b0, d, 1'b1, 1'b0);
        d = random_word();
        add_row("data_bit95", d, word_t'(1) << 95, '0, 1'b0, d, 1'b1, 1'b0);
        for (int i = 0; i < 4; i++) begin
            d = random_word();
            a = $urandom_range(94, 1);
            add_row($sformatf("data_bit%0d", a), d, word_t'(1) << a, '0, 1'b0, d, 1'b1, 1'b0);
        end
        for (int j = 0; j < `ECC_PARITY_WIDTH; j++) begin
            d = random_word();
            add_row($sformatf("check_bit%0d", j), d, '0, check_t'(1) << j, 1'b0, d, 1'b1, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            d    = random_word();
            a    = $urandom_range(47, 0);
            b    = a + 1 + $urandom_range(47, 0);
            flip = (word_t'(1) << a) | (word_t'(1) << b);
            add_row($sformatf("double_data_%0d", i), d, flip, '0, 1'b0, d ^ flip, 1'b0, 1'b1);
        end
        for (int i = 0; i < 2; i++) begin
            d    = random_word();
            flip = word_t'(1) << $urandom_range(95, 0);
            c    = $urandom_range(7, 0);
            add_row($sformatf("double_mixed_%0d", i), d, flip, check_t'(1) << c, 1'b0,
                    d ^ flip, 1'b0, 1'b1);
        end
        d    = random_word();
        flip = word_t'(1) << $urandom_range(95, 0);
        add_row("bypass_single", d, flip, '0, 1'b1, d ^ flip, 1'b0, 1'b0);
        d    = random_word();
        flip = (word_t'(1) << 3) | (word_t'(1) << 60);
        add_row("bypass_double", d, flip, '0, 1'b1, d ^ flip, 1'b0, 1'b0);
        d = random_word();
        add_row("bypass_check", d, '0, check_t'(1) << 5, 1'b1, d, 1'b0, 1'b0);
    endtask

    // Called on a rising edge. Holds the row for exactly one cycle.
    task automatic drive_row(input int i);
        #1;
        in_valid   = 1'b1;
        data_in    = tbl_data[i] ^ tbl_dflip[i];
        parity_in  = ref_encode(tbl_data[i]) ^ tbl_cflip[i];
        bypass     = tbl_bypass[i];
        exp_name   = tbl_name[i];
        exp_parity = ref_encode(tbl_data[i] ^ tbl_dflip[i]);
        exp_data   = tbl_exp_data[i];
        exp_sbit   = tbl_exp_sbit[i];
        exp_dbit   = tbl_exp_dbit[i];
        @(posedge clk);
    endtask

    task automatic wait_reset(output logic ok);
        int waited;
        waited = 0;
        while (rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        ok = (rst_n === 1'b1);
        if (!ok) begin
            $display("Reset was never released");
        end
    endtask

    task automatic wait_results(output logic ok);
        int waited;
        waited = 0;
        while (checked < ROWS && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        ok = (checked >= ROWS);
        if (!ok) begin
            $display("Timed out waiting for out_valid, %0d of %0d rows seen", checked, ROWS);
        end
    endtask

    initial begin
        logic ok;
        in_valid   = 1'b0;
        data_in    = '0;
        parity_in  = '0;
        bypass     = 1'b0;
        exp_name   = '0;
        exp_parity = '0;
        exp_data   = '0;
        exp_sbit   = 1'b0;
        exp_dbit   = 1'b0;
        void'($urandom(32'hf984_02c9));
        fill_table();

        wait_reset(ok);
        if (ok) begin
            // Rows go back to back, one per cycle.
            for (int i = 0; i < n_rows; i++) begin
                drive_row(i);
            end
            #1;
            in_valid = 1'b0;
            bypass   = 1'b0;
            wait_results(ok);
            if (ok) begin
                // One idle cycle on the last corrupted word checks that out_valid and the flags drop.
                @(negedge clk);
                #1;
            end
        end

        $display("Rows checked: %0d of %0d, errors: %0d", checked, ROWS, errors);
        if (ok && errors == 0 && checked == ROWS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ecc_96_top.f */
+incdir+logic
logic/ecc_pkg.sv
logic/ecc_check_if.sv
logic/ecc_parity_gen.sv
logic/ecc_syndrome_decode.sv
logic/ecc_correct_stage.sv
logic/ecc_96_top.sv
sim/ecc_tb_clock.sv
sim/ecc_checker.sv
sim/ecc_96_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ECC testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=ecc_96_sim
log_file=sim.log

verilator --binary --timing \
    -f ecc_96_top.f \
    --top-module ecc_96_tb \
    -Mdir "$build_dir" \
    -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result.
if grep -q "Test failed" "$log_file"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without a reported failure"
exit 0
